//--- rtl/nn_ctrl_pkg.sv
package nn_ctrl_pkg;

  ////////////////////
  // layer type codes
  ////////////////////

  // 5 to 15 reserved, flagged illegal by the decoder
  typedef enum logic [3:0] {
    conv   = 4'd0,
    pool   = 4'd1,
    act    = 4'd2,
    fc     = 4'd3,
    bypass = 4'd4
  } layer_type_e;

  ////////////////////
  // instruction word
  ////////////////////

  // conv, pool, act, bypass view
  typedef struct packed {
    layer_type_e layer_type;
    logic [3:0]  kernel_size;
    logic [3:0]  stride;
    logic        relu_en;
    logic        pool_en;
  } conv_fields_t;

  // gemv view, middle byte is the vector length
  typedef struct packed {
    layer_type_e layer_type;
    logic [7:0]  vec_len;
    logic        relu_en;
    logic        pool_en;
  } fc_fields_t;

  // same 14 bits, two readings
  typedef union packed {
    conv_fields_t conv_view;
    fc_fields_t   fc_view;
  } inst_word_u;

  ////////////////////
  // decoded layer
  ////////////////////

  typedef struct packed {
    layer_type_e layer_type;
    logic [3:0]  kernel_size;
    logic [3:0]  stride;
    logic [7:0]  vec_len;
    logic        relu_en;
    logic        pool_en;
    logic        illegal;
  } layer_info_t;

  // command to the datapath
  typedef struct packed {
    layer_type_e layer_type;
    logic [7:0]  out_per_row;
    logic [7:0]  steps_per_out;
    logic        relu_en;
    logic        pool_en;
    logic        illegal;
    logic        geo_err;
  } layer_cmd_t;

endpackage

//--- rtl/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
  parameter int queue_depth = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  nn_ctrl_pkg::inst_word_u push_inst,
  input  logic                   pop,
  output logic                   q_valid,
  output nn_ctrl_pkg::inst_word_u q_inst,
  output logic                   credit
);

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  // storage, no reset needed
  nn_ctrl_pkg::inst_word_u mem [queue_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // head of queue straight to the decoder
  assign q_valid = (count != '0);
  assign q_inst  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_inst;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // circular pointers
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
      // one credit back per freed slot
      credit <= pop;
    end
  end

  // host must hold a credit, so never a push into a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> (count < cnt_w'(queue_depth)));

  // decoder only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> (count != '0));

endmodule

//--- rtl/layer_decoder.sv
`timescale 1ns/1ps

module layer_decoder (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     q_valid,
  input  nn_ctrl_pkg::inst_word_u   q_inst,
  input  logic                     cmd_sent,
  output logic                     pop,
  output logic                     decoded,
  output nn_ctrl_pkg::layer_info_t  layer_info
);

  // high from pop until the merge sends the command
  logic busy;

  // take the next word only when idle
  assign pop = q_valid && !busy;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      decoded <= 1'b0;
    end else begin
      // one-cycle pulse, fields valid alongside it
      decoded <= pop;
      if (pop) begin
        busy <= 1'b1;
      end else if (cmd_sent) begin
        busy <= 1'b0;
      end
    end
  end

  ////////////////////
  // field latch
  ////////////////////

  always_ff @(posedge clk) begin
    if (pop) begin
      layer_info.layer_type  <= q_inst.conv_view.layer_type;
      // kernel and stride through the conv view
      layer_info.kernel_size <= q_inst.conv_view.kernel_size;
      layer_info.stride      <= q_inst.conv_view.stride;
      // same bits as one length through the fc view
      layer_info.vec_len     <= q_inst.fc_view.vec_len;
      layer_info.relu_en     <= q_inst.conv_view.relu_en;
      layer_info.pool_en     <= q_inst.conv_view.pool_en;
      // reserved codes above bypass
      layer_info.illegal     <= (q_inst.conv_view.layer_type > nn_ctrl_pkg::bypass);
    end
  end

  // a command only completes a layer that was taken
  a_sent_when_busy: assert property (@(posedge clk) disable iff (rst)
    cmd_sent |-> busy);

endmodule

//--- rtl/geometry_unit.sv
`timescale 1ns/1ps

module geometry_unit #(
  parameter int fmap_width = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    decoded,
  input  nn_ctrl_pkg::layer_info_t layer_info,
  output logic                    geo_done,
  output logic [7:0]              geo_out,
  output logic                    geo_err
);

  // remaining span for the divide loop
  logic [7:0] rem;
  logic       running;
  logic       bad_geo;

  // zero stride or kernel wider than the row
  assign bad_geo = (layer_info.stride == 4'd0) ||
                   ({4'd0, layer_info.kernel_size} > 8'(fmap_width));

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      running  <= 1'b0;
      geo_done <= 1'b0;
      geo_out  <= 8'd0;
      geo_err  <= 1'b0;
      rem      <= 8'd0;
    end else begin
      geo_done <= 1'b0;
      if (decoded) begin
        geo_err <= 1'b0;
        unique case (layer_info.layer_type)
          nn_ctrl_pkg::conv, nn_ctrl_pkg::pool: begin
            if (bad_geo) begin
              geo_err  <= 1'b1;
              geo_out  <= 8'd0;
              geo_done <= 1'b1;
            end else begin
              // first position counted up front
              rem     <= 8'(fmap_width) - {4'd0, layer_info.kernel_size};
              geo_out <= 8'd1;
              running <= 1'b1;
            end
          end
          nn_ctrl_pkg::act, nn_ctrl_pkg::bypass: begin
            geo_out  <= 8'(fmap_width);
            geo_done <= 1'b1;
          end
          nn_ctrl_pkg::fc: begin
            geo_out  <= 8'd1;
            geo_done <= 1'b1;
          end
          // reserved types
          default: begin
            geo_out  <= 8'd0;
            geo_done <= 1'b1;
          end
        endcase
      end else if (running) begin
        // one subtract per cycle
        if (rem >= {4'd0, layer_info.stride}) begin
          rem     <= rem - {4'd0, layer_info.stride};
          geo_out <= geo_out + 8'd1;
        end else begin
          running  <= 1'b0;
          geo_done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/work_unit.sv
`timescale 1ns/1ps

module work_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    decoded,
  input  nn_ctrl_pkg::layer_info_t layer_info,
  output logic                    work_done,
  output logic [7:0]              steps
);

  // shift-and-add operands
  logic [7:0] mcand;
  logic [3:0] mplier;
  logic [1:0] bit_cnt;
  logic       running;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      running   <= 1'b0;
      work_done <= 1'b0;
      steps     <= 8'd0;
      mcand     <= 8'd0;
      mplier    <= 4'd0;
      bit_cnt   <= 2'd0;
    end else begin
      work_done <= 1'b0;
      if (decoded) begin
        steps <= 8'd0;
        unique case (layer_info.layer_type)
          nn_ctrl_pkg::conv, nn_ctrl_pkg::pool: begin
            // k times k, one multiplier bit per cycle
            mcand   <= {4'd0, layer_info.kernel_size};
            mplier  <= layer_info.kernel_size;
            bit_cnt <= 2'd0;
            running <= 1'b1;
          end
          nn_ctrl_pkg::fc: begin
            steps     <= layer_info.vec_len;
            work_done <= 1'b1;
          end
          nn_ctrl_pkg::act: begin
            steps     <= 8'd1;
            work_done <= 1'b1;
          end
          // bypass and reserved do no work
          default: work_done <= 1'b1;
        endcase
      end else if (running) begin
        if (mplier[0]) begin
          steps <= steps + mcand;
        end
        mcand   <= mcand << 1;
        mplier  <= mplier >> 1;
        bit_cnt <= bit_cnt + 2'd1;
        // fourth bit ends the multiply
        if (bit_cnt == 2'd3) begin
          running   <= 1'b0;
          work_done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/command_merge.sv
`timescale 1ns/1ps

module command_merge #(
  parameter int cmd_credits = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  nn_ctrl_pkg::layer_info_t layer_info,
  input  logic                    geo_done,
  input  logic [7:0]              geo_out,
  input  logic                    geo_err,
  input  logic                    work_done,
  input  logic [7:0]              steps,
  input  logic                    cmd_credit,
  output logic                    cmd_valid,
  output nn_ctrl_pkg::layer_cmd_t  cmd,
  output logic                    cmd_sent
);

  localparam int cred_w = $clog2(cmd_credits + 1);

  logic              geo_seen;
  logic              work_seen;
  logic [cred_w-1:0] credit_cnt;
  logic              send;

  // both results in and a slot free downstream
  assign send = geo_seen && work_seen && (credit_cnt != '0);

  ////////////////////
  // flags and credits
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      geo_seen   <= 1'b0;
      work_seen  <= 1'b0;
      credit_cnt <= cred_w'(cmd_credits);
      cmd_valid  <= 1'b0;
      cmd_sent   <= 1'b0;
    end else begin
      geo_seen  <= (geo_seen | geo_done) & ~send;
      work_seen <= (work_seen | work_done) & ~send;
      cmd_valid <= send;
      // decoder released in the same cycle the command shows
      cmd_sent  <= send;
      unique case ({send, cmd_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // command register, unit outputs are held so sample at send
  always_ff @(posedge clk) begin
    if (send) begin
      cmd.layer_type    <= layer_info.layer_type;
      cmd.out_per_row   <= geo_out;
      cmd.steps_per_out <= steps;
      cmd.relu_en       <= layer_info.relu_en;
      cmd.pool_en       <= layer_info.pool_en;
      cmd.illegal       <= layer_info.illegal;
      cmd.geo_err       <= geo_err;
    end
  end

  // each unit reports once per layer
  a_one_result: assert property (@(posedge clk) disable iff (rst)
    !(geo_done && geo_seen) && !(work_done && work_seen));

  // datapath never returns more than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= cred_w'(cmd_credits));

endmodule

//--- rtl/nn_ctrl_top.sv
`timescale 1ns/1ps

module nn_ctrl_top #(
  parameter int queue_depth = 4,
  parameter int fmap_width  = 16,
  parameter int cmd_credits = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_valid,
  input  nn_ctrl_pkg::inst_word_u inst,
  output logic                   inst_credit,
  output logic                   cmd_valid,
  output nn_ctrl_pkg::layer_cmd_t cmd,
  input  logic                   cmd_credit
);

  // queue to decoder
  logic                    q_valid;
  nn_ctrl_pkg::inst_word_u  q_inst;
  logic                    pop;

  // decoder to units
  logic                    decoded;
  nn_ctrl_pkg::layer_info_t layer_info;
  logic                    cmd_sent;

  // unit results
  logic                    geo_done;
  logic [7:0]              geo_out;
  logic                    geo_err;
  logic                    work_done;
  logic [7:0]              steps;

  inst_queue #(
    .queue_depth(queue_depth)
  ) i_inst_queue (
    .clk(clk), .rst(rst),
    .push(inst_valid), .push_inst(inst),
    .pop(pop), .q_valid(q_valid), .q_inst(q_inst),
    .credit(inst_credit)
  );

  layer_decoder i_layer_decoder (
    .clk(clk), .rst(rst),
    .q_valid(q_valid), .q_inst(q_inst), .cmd_sent(cmd_sent),
    .pop(pop), .decoded(decoded), .layer_info(layer_info)
  );

  // geometry and work run side by side
  geometry_unit #(
    .fmap_width(fmap_width)
  ) i_geometry_unit (
    .clk(clk), .rst(rst),
    .decoded(decoded), .layer_info(layer_info),
    .geo_done(geo_done), .geo_out(geo_out), .geo_err(geo_err)
  );

  work_unit i_work_unit (
    .clk(clk), .rst(rst),
    .decoded(decoded), .layer_info(layer_info),
    .work_done(work_done), .steps(steps)
  );

  command_merge #(
    .cmd_credits(cmd_credits)
  ) i_command_merge (
    .clk(clk), .rst(rst),
    .layer_info(layer_info),
    .geo_done(geo_done), .geo_out(geo_out), .geo_err(geo_err),
    .work_done(work_done), .steps(steps),
    .cmd_credit(cmd_credit),
    .cmd_valid(cmd_valid), .cmd(cmd), .cmd_sent(cmd_sent)
  );

endmodule

//--- tests/nn_ctrl_tb.sv
`timescale 1ns/1ps

module nn_ctrl_tb;

  // narrower row than the default so a 4-bit kernel can overhang it
  localparam int queue_depth     = 4;
  localparam int fmap_width      = 12;
  localparam int cmd_credits     = 2;
  localparam int cycles_per_line = 60;
  localparam int cred_w          = 4;

  typedef logic [cred_w-1:0] credit_t;

  logic                    clk;
  logic                    rst;
  logic                    inst_valid;
  nn_ctrl_pkg::inst_word_u inst;
  logic                    inst_credit;
  logic                    cmd_valid;
  nn_ctrl_pkg::layer_cmd_t cmd;
  logic                    cmd_credit;

  // trace contents, in push order
  nn_ctrl_pkg::inst_word_u inst_q[$];
  nn_ctrl_pkg::layer_cmd_t exp_q[$];
  string                   name_q[$];

  // cycles at which the datapath hands a credit back
  int      due_q[$];
  int      seed = 85;
  int      cycle = 0;
  int      limit;
  int      n_lines;
  int      quiet = 0;
  credit_t host_credits;
  credit_t dp_credits;

  nn_ctrl_top #(
    .queue_depth(queue_depth),
    .fmap_width(fmap_width),
    .cmd_credits(cmd_credits)
  ) i_nn_ctrl_top (
    .clk(clk), .rst(rst),
    .inst_valid(inst_valid), .inst(inst), .inst_credit(inst_credit),
    .cmd_valid(cmd_valid), .cmd(cmd), .cmd_credit(cmd_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // failure and compare
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_cmd(input string name, input nn_ctrl_pkg::layer_cmd_t exp_cmd,
                           input nn_ctrl_pkg::layer_cmd_t act_cmd);
    if (act_cmd !== exp_cmd) begin
      abort_run($sformatf("** Error: %s expected %h actual %h", name, exp_cmd, act_cmd));
    end
  endtask

  task automatic check_credit_count(input string name, input credit_t exp_cnt,
                                    input credit_t act_cnt);
    if (act_cnt !== exp_cnt) begin
      abort_run($sformatf("** Error: %s expected %0d actual %0d", name, exp_cnt, act_cnt));
    end
  endtask

  ////////////////////
  // trace reader
  ////////////////////

  task automatic read_trace();
    int                      fd;
    int                      r;
    int                      word;
    int                      typ;
    int                      outs;
    int                      stp;
    int                      relu;
    int                      pool;
    int                      ill;
    int                      gerr;
    logic [1023:0]           line;
    logic [8*24-1:0]         name_buf;
    nn_ctrl_pkg::inst_word_u w;
    nn_ctrl_pkg::layer_cmd_t c;
    fd = $fopen("tests/nn_ctrl_trace.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the trace file tests/nn_ctrl_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      r = $sscanf(line, "%s %h %h %d %d %d %d %d %d",
                  name_buf, word, typ, outs, stp, relu, pool, ill, gerr);
      // comment and blank lines fall short of nine fields
      if (r == 9) begin
        w               = word[13:0];
        c.layer_type    = nn_ctrl_pkg::layer_type_e'(typ[3:0]);
        c.out_per_row   = outs[7:0];
        c.steps_per_out = stp[7:0];
        c.relu_en       = relu[0];
        c.pool_en       = pool[0];
        c.illegal       = ill[0];
        c.geo_err       = gerr[0];
        inst_q.push_back(w);
        exp_q.push_back(c);
        name_q.push_back($sformatf("%0s", name_buf));
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // per-cycle models
  ////////////////////

  // compare each command against the head of the trace
  task automatic watch_commands();
    int delay;
    if (cmd_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("surplus command: cmd_valid rose with no trace line left");
      end else if (dp_credits == 0) begin
        abort_run("command sent while the DUT held no datapath credit");
      end else begin
        check_cmd(name_q[0], exp_q[0], cmd);
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
        dp_credits = dp_credits - 1'b1;
        // credit comes back 0 to 7 cycles later
        delay = $unsigned($random(seed)) % 8;
        due_q.push_back(cycle + delay);
      end
    end
  endtask

  // datapath side, one credit per cycle at most, in order
  task automatic return_credits();
    cmd_credit = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cycle) begin
      cmd_credit = 1'b1;
      void'(due_q.pop_front());
      dp_credits = dp_credits + 1'b1;
    end
  endtask

  // host side, pushes whenever it holds a credit
  task automatic drive_host();
    if (inst_credit) begin
      if (host_credits == credit_t'(queue_depth)) begin
        abort_run("instruction credit returned with no word outstanding");
      end
      host_credits = host_credits + 1'b1;
    end
    if (host_credits != 0 && inst_q.size() != 0) begin
      inst_valid   = 1'b1;
      inst         = inst_q.pop_front();
      host_credits = host_credits - 1'b1;
    end else begin
      inst_valid = 1'b0;
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    cmd_credit   = 1'b0;
    host_credits = credit_t'(queue_depth);
    dp_credits   = credit_t'(cmd_credits);
    read_trace();
    n_lines = exp_q.size();
    limit   = cycles_per_line * n_lines;
    repeat (2) @(posedge clk);
    @(negedge clk);
    // handshake outputs idle out of reset
    if (cmd_valid !== 1'b0 || inst_credit !== 1'b0) begin
      abort_run("cmd_valid or inst_credit not low after reset");
    end
    rst = 1'b0;
    // run until every command is in and every credit is home
    while (quiet < 8) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit) begin
        abort_run("timeout: no command arrived before the cycle limit");
      end
      watch_commands();
      return_credits();
      drive_host();
      if (exp_q.size() == 0 && due_q.size() == 0) begin
        quiet++;
      end
    end
    check_credit_count("host credits at end", credit_t'(queue_depth), host_credits);
    // merge counter back to full once every credit is home
    check_credit_count("datapath credits at end", credit_t'(cmd_credits),
                       credit_t'(i_nn_ctrl_top.i_command_merge.credit_cnt));
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- nn_ctrl.f
rtl/nn_ctrl_pkg.sv
rtl/inst_queue.sv
rtl/layer_decoder.sv
rtl/geometry_unit.sv
rtl/work_unit.sv
rtl/command_merge.sv
rtl/nn_ctrl_top.sv
tests/nn_ctrl_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := nn_ctrl_tb
FILELIST  := nn_ctrl.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run from the project root so the trace path resolves
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/nn_ctrl_trace.txt
# test name, instruction (hex), expected type (hex), out_per_row, steps_per_out
# then relu pool illegal geo_err; values for a 12-wide feature-map row
conv_k3_s1   0C6  0 10   9 1 0 0 0
conv_k5_s2   14B  0  4  25 1 1 0 0
pool_k2_s2   489  1  6   4 0 1 0 0
pool_k3_s3   4CD  1  4   9 0 1 0 0
conv_k1_s1   044  0 12   1 0 0 0 0
conv_k7_s4   1D3  0  2  49 1 1 0 0
conv_k12_s5  314  0  1 144 0 0 0 0
fc_len200    F22  3  1 200 1 0 0 0
fc_len149    E55  3  1 149 0 1 0 0
fc_len255    FFF  3  1 255 1 1 0 0
act_plain    802  2 12   1 1 0 0 0
act_odd_bits BC2  2 12   1 1 0 0 0
bypass_odd   11CC 4 12   0 0 0 0 0
rsv_type5    14C7 5  0   0 1 1 1 0
rsv_type15   3FFF f  0   0 1 1 1 0
geo_stride0  100  0  0  16 0 0 0 1
geo_kernel15 3C6  0  0 225 1 0 0 1
